// File: hdl/pic_pkg.sv
/* PIC shared definitions
   Register map, widths and the structs passed between the PIC blocks */
package pic_pkg;

   // Sizing
   localparam int NUM_INTS = 32;   // Slot 0 is reserved
   localparam int ID_W     = 5;
   localparam int PRIO_W   = 4;

   typedef logic [ID_W-1:0]   int_id_t;
   typedef logic [PRIO_W-1:0] prio_t;
   typedef logic [31:0]       word_t;

   //////////////////////////////////////////////////////////////////////
   // Register map
   //////////////////////////////////////////////////////////////////////
   localparam word_t PIC_BASE_ADDR = 32'hF00C_0000;

   localparam word_t PRIO_OFS   = 32'h0000_0000;   // Priority bank
   localparam word_t PEND_OFS   = 32'h0000_1000;   // Single pending word
   localparam word_t ENABLE_OFS = 32'h0000_2000;   // Enable bank
   localparam word_t CONFIG_OFS = 32'h0000_3000;   // Global config, bit 0 reverses order
   localparam word_t GW_CFG_OFS = 32'h0000_4000;   // Gateway config bank
   localparam word_t GW_CLR_OFS = 32'h0000_5000;   // Gateway clear bank, write only

   // Level that raises wake-up in normal order
   localparam prio_t MAX_PRIO = 4'd15;

   //////////////////////////////////////////////////////////////////////
   // Port structs
   //////////////////////////////////////////////////////////////////////

   // Register port request, sampled every cycle
   typedef struct packed {
      logic  wren;
      logic  rden;
      word_t wraddr;
      word_t rdaddr;
      word_t wr_data;
   } pic_bus_req_t;

   // Gateway config word layout, bit 1 type and bit 0 polarity
   typedef struct packed {
      logic edge_mode;   // 1 = latched edge
      logic polarity;    // 1 = active low
   } pic_gw_cfg_t;

   // Threshold inputs from the core
   typedef struct packed {
      prio_t meicurpl;
      prio_t meipt;
   } pic_core_t;

   // Registered outputs to the core
   typedef struct packed {
      logic    mexintpend;
      int_id_t claimid;
      prio_t   pl;
      logic    mhwakeup;
   } pic_claim_t;

endpackage

// File: hdl/pic_gateway.sv
/* Interrupt gateway for one source
   Two-flop synchronizer, polarity select and latched edge mode */
module pic_gateway
   import pic_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        req,
   input  pic_gw_cfg_t cfg,
   input  logic        clear,
   output logic        pending
);

   logic sync_q1;
   logic sync_q2;
   logic active;
   logic latch_q;

   // Async source into the clk domain
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q1 <= 1'b0;
         sync_q2 <= 1'b0;
      end else begin
         sync_q1 <= req;
         sync_q2 <= sync_q1;
      end
   end

   assign active = sync_q2 ^ cfg.polarity;   // Active level after polarity

   // Edge latch, held until a software clear
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         latch_q <= 1'b0;
      end else begin
         latch_q <= cfg.edge_mode & (active | (latch_q & ~clear));
      end
   end

   // Level mode passes the live level straight on
   assign pending = cfg.edge_mode ? (active | latch_q) : active;

endmodule

// File: hdl/pic_regs.sv
/* PIC register block
   Captures register port requests, holds per-source config and muxes read data */
module pic_regs
   import pic_pkg::*;
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  pic_bus_req_t               bus,
   input  logic [NUM_INTS-1:0]        gw_pending,
   output pic_gw_cfg_t [NUM_INTS-1:0] gw_cfg,
   output logic [NUM_INTS-1:0]        gw_clear,
   output prio_t [NUM_INTS-1:0]       eff_prio,
   output logic                       rev_order,
   output word_t                      rd_data
);

   pic_bus_req_t         bus_q;    // Request captured at the edge
   prio_t [NUM_INTS-1:0] prio_q;
   logic [NUM_INTS-1:0]  en_q;
   int_id_t              wr_idx;
   int_id_t              rd_idx;

   logic wr_prio;
   logic wr_en;
   logic wr_gw;
   logic wr_clr;
   logic wr_cfg;
   logic rd_prio;
   logic rd_en;
   logic rd_gw;
   logic rd_pend;
   logic rd_cfg;

   // Bank match ignores the source index in bits 6:2
   function automatic logic bank_hit(word_t addr, word_t ofs);
      word_t base;
      base = PIC_BASE_ADDR + ofs;
      return addr[31:ID_W+2] == base[31:ID_W+2];
   endfunction

   // Single register, whole word address must match
   function automatic logic word_hit(word_t addr, word_t ofs);
      word_t base;
      base = PIC_BASE_ADDR + ofs;
      return addr[31:2] == base[31:2];
   endfunction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bus_q <= '0;
      end else begin
         bus_q <= bus;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////////////////////////
   assign wr_idx = bus_q.wraddr[ID_W+1:2];
   assign rd_idx = bus_q.rdaddr[ID_W+1:2];

   // Slot 0 never decodes in the banks
   assign wr_prio = bus_q.wren && bank_hit(bus_q.wraddr, PRIO_OFS) && (wr_idx != '0);
   assign wr_en   = bus_q.wren && bank_hit(bus_q.wraddr, ENABLE_OFS) && (wr_idx != '0);
   assign wr_gw   = bus_q.wren && bank_hit(bus_q.wraddr, GW_CFG_OFS) && (wr_idx != '0);
   assign wr_clr  = bus_q.wren && bank_hit(bus_q.wraddr, GW_CLR_OFS) && (wr_idx != '0);
   assign wr_cfg  = bus_q.wren && word_hit(bus_q.wraddr, CONFIG_OFS);

   assign rd_prio = bus_q.rden && bank_hit(bus_q.rdaddr, PRIO_OFS) && (rd_idx != '0);
   assign rd_en   = bus_q.rden && bank_hit(bus_q.rdaddr, ENABLE_OFS) && (rd_idx != '0);
   assign rd_gw   = bus_q.rden && bank_hit(bus_q.rdaddr, GW_CFG_OFS) && (rd_idx != '0);
   assign rd_pend = bus_q.rden && word_hit(bus_q.rdaddr, PEND_OFS);
   assign rd_cfg  = bus_q.rden && word_hit(bus_q.rdaddr, CONFIG_OFS);

   //////////////////////////////////////////////////////////////////////
   // Config registers
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         prio_q    <= '0;
         en_q      <= '0;
         gw_cfg    <= '0;
         rev_order <= 1'b0;
      end else begin
         if (wr_prio) begin
            prio_q[wr_idx] <= bus_q.wr_data[PRIO_W-1:0];
         end
         if (wr_en) begin
            en_q[wr_idx] <= bus_q.wr_data[0];
         end
         if (wr_gw) begin
            gw_cfg[wr_idx] <= pic_gw_cfg_t'(bus_q.wr_data[1:0]);
         end
         if (wr_cfg) begin
            rev_order <= bus_q.wr_data[0];
         end
      end
   end

   // One-cycle clear strobe to the addressed gateway
   always_comb begin
      gw_clear = '0;
      if (wr_clr) begin
         gw_clear[wr_idx] = 1'b1;
      end
   end

   // Masked priority seen by the arbiter, inverted for reversed order
   always_comb begin
      for (int i = 0; i < NUM_INTS; i++) begin
         if (gw_pending[i] && en_q[i]) begin
            eff_prio[i] = rev_order ? ~prio_q[i] : prio_q[i];
         end else begin
            eff_prio[i] = '0;
         end
      end
   end

   // Read data, zero for unmapped addresses and idle cycles
   always_comb begin
      rd_data = '0;
      if (rd_prio) begin
         rd_data = word_t'(prio_q[rd_idx]);
      end else if (rd_en) begin
         rd_data = word_t'(en_q[rd_idx]);
      end else if (rd_gw) begin
         rd_data = word_t'(gw_cfg[rd_idx]);
      end else if (rd_pend) begin
         rd_data = word_t'(gw_pending);   // Live gateway outputs
      end else if (rd_cfg) begin
         rd_data = word_t'(rev_order);
      end
   end

endmodule

// File: hdl/pic_arbiter.sv
/* PIC priority arbiter
   Binary compare-and-select tree picking the highest pending priority */
module pic_arbiter
   import pic_pkg::*;
(
   input  prio_t [NUM_INTS-1:0] eff_prio,
   output int_id_t              win_id,
   output prio_t                win_prio
);

   // Level 0 holds the leaves, level ID_W the single root entry
   int_id_t [ID_W:0][NUM_INTS-1:0] lvl_id;
   prio_t   [ID_W:0][NUM_INTS-1:0] lvl_prio;

   always_comb begin
      lvl_id   = '0;
      lvl_prio = '0;

      // Leaves in id order so the left entry is always the lower id
      for (int i = 0; i < NUM_INTS; i++) begin
         lvl_id[0][i]   = int_id_t'(i);
         lvl_prio[0][i] = eff_prio[i];
      end

      //////////////////////////////////////////////////////////////////////
      // Compare and select, each level halves the field
      //////////////////////////////////////////////////////////////////////
      for (int l = 0; l < ID_W; l++) begin
         for (int m = 0; m < (NUM_INTS >> (l + 1)); m++) begin
            // Right side only on strictly greater, ties keep the lower id
            if (lvl_prio[l][2*m+1] > lvl_prio[l][2*m]) begin
               lvl_id[l+1][m]   = lvl_id[l][2*m+1];
               lvl_prio[l+1][m] = lvl_prio[l][2*m+1];
            end else begin
               lvl_id[l+1][m]   = lvl_id[l][2*m];
               lvl_prio[l+1][m] = lvl_prio[l][2*m];
            end
         end
      end
   end

   // Nothing pending falls through to slot 0 at priority 0
   assign win_id   = lvl_id[ID_W][0];
   assign win_prio = lvl_prio[ID_W][0];

endmodule

// File: hdl/pic_notify.sv
/* PIC notification stage
   Threshold compare and registered claim, level and wake-up to the core */
module pic_notify
   import pic_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  int_id_t    win_id,
   input  prio_t      win_prio,
   input  logic       rev_order,
   input  pic_core_t  core,
   output pic_claim_t claim
);

   prio_t pl_nxt;
   prio_t meipt_eff;
   prio_t curpl_eff;
   prio_t wake_lvl;
   logic  intpend_nxt;

   // Back to the programmed scale
   assign pl_nxt = rev_order ? ~win_prio : win_prio;

   // Thresholds moved onto the arbiter's scale
   assign meipt_eff = rev_order ? ~core.meipt : core.meipt;
   assign curpl_eff = rev_order ? ~core.meicurpl : core.meicurpl;

   assign intpend_nxt = (win_prio > meipt_eff) && (win_prio > curpl_eff);
   assign wake_lvl    = rev_order ? '0 : MAX_PRIO;   // Most urgent programmed level

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         claim <= '0;
      end else begin
         claim.claimid    <= win_id;
         claim.pl         <= pl_nxt;
         claim.mexintpend <= intpend_nxt;
         claim.mhwakeup   <= (pl_nxt == wake_lvl);
      end
   end

endmodule

// File: hdl/pic_top.sv
/* PIC top level
   Gateways, register block, arbiter and notifier for 31 external sources */
module pic_top
   import pic_pkg::*;
(
   input  logic                clk,
   input  logic                arst_n,
   input  logic [NUM_INTS-1:0] src_req,
   input  pic_bus_req_t        bus,
   input  pic_core_t           core,
   output word_t               rd_data,
   output pic_claim_t          claim
);

   pic_gw_cfg_t [NUM_INTS-1:0] gw_cfg;
   logic [NUM_INTS-1:0]        gw_clear;
   logic [NUM_INTS-1:0]        gw_pending;
   prio_t [NUM_INTS-1:0]       eff_prio;
   logic                       rev_order;
   int_id_t                    win_id;
   prio_t                      win_prio;

   pic_regs u_regs (
      .clk        (clk),
      .arst_n     (arst_n),
      .bus        (bus),
      .gw_pending (gw_pending),
      .gw_cfg     (gw_cfg),
      .gw_clear   (gw_clear),
      .eff_prio   (eff_prio),
      .rev_order  (rev_order),
      .rd_data    (rd_data)
   );

   assign gw_pending[0] = 1'b0;   // Reserved slot

   for (genvar i = 1; i < NUM_INTS; i++) begin : g_src
      pic_gateway u_gw (
         .clk     (clk),
         .arst_n  (arst_n),
         .req     (src_req[i]),
         .cfg     (gw_cfg[i]),
         .clear   (gw_clear[i]),
         .pending (gw_pending[i])
      );
   end

   pic_arbiter u_arb (
      .eff_prio (eff_prio),
      .win_id   (win_id),
      .win_prio (win_prio)
   );

   pic_notify u_notify (
      .clk       (clk),
      .arst_n    (arst_n),
      .win_id    (win_id),
      .win_prio  (win_prio),
      .rev_order (rev_order),
      .core      (core),
      .claim     (claim)
   );

endmodule

// File: dv/pic_sva.sv
/* PIC output assertions
   Reset, claim and read-data rules on the top-level ports */
module pic_sva
   import pic_pkg::*;
(
   input logic         clk,
   input logic         arst_n,
   input pic_bus_req_t bus,
   input word_t        rd_data,
   input pic_claim_t   claim
);

   // Claim held clear under reset
   a_reset_claim: assert property (@(posedge clk) !arst_n |-> claim == '0)
      else $error("claim is not zero during reset");

   a_pend_id: assert property (@(posedge clk) disable iff (!arst_n)
      claim.mexintpend |-> claim.claimid != '0)
      else $error("interrupt request raised with claim id 0");

   // Read data only in the cycle after a captured read
   a_rd_idle: assert property (@(posedge clk) disable iff (!arst_n)
      !$past(bus.rden) |-> rd_data == '0)
      else $error("read data not zero outside a read cycle");

endmodule

bind pic_top pic_sva u_sva (
   .clk     (clk),
   .arst_n  (arst_n),
   .bus     (bus),
   .rd_data (rd_data),
   .claim   (claim)
);

// File: dv/pic_tb.sv
/* PIC testbench
   Random and directed tests of registers, arbitration, thresholds, edge mode and order */
module pic_tb
   import pic_pkg::*;
();

   localparam int MAX_CYCLES = 20000;   // Tests run close to 5000 cycles

   logic                clk;
   logic                arst_n;
   logic [NUM_INTS-1:0] src_req;
   pic_bus_req_t        bus;
   pic_core_t           core;
   word_t               rd_data;
   pic_claim_t          claim;

   // Reference model state
   prio_t               prio_m [NUM_INTS];
   logic [NUM_INTS-1:0] en_m;
   logic [NUM_INTS-1:0] pol_m;
   logic [NUM_INTS-1:0] edge_m;
   logic [NUM_INTS-1:0] latch_m;   // Modeled gateway edge latches
   logic                rev_m;

   word_t      rng_state = 32'h1027_d812;
   int         pass_cnt;
   int         err_cnt;
   int         cycles;
   pic_claim_t exp_claim;
   event       do_check;
   event       check_done;

   pic_top u_pic_top (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Model and helpers
   //////////////////////////////////////////////////////////////////////
   function automatic word_t next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Latch sets on the active level in edge mode, dropped when leaving it
   function automatic void update_latches();
      logic [NUM_INTS-1:0] act;
      act = src_req ^ pol_m;
      latch_m = edge_m & (latch_m | act);
   endfunction

   function automatic logic [NUM_INTS-1:0] pend_vec(input logic [NUM_INTS-1:0] src,
                                                    input logic [NUM_INTS-1:0] lat);
      logic [NUM_INTS-1:0] act;
      act = src ^ pol_m;
      return {act[NUM_INTS-1:1] | lat[NUM_INTS-1:1], 1'b0};   // Slot 0 never pends
   endfunction

   function automatic pic_claim_t ref_claim(input logic [NUM_INTS-1:0] src,
                                            input logic [NUM_INTS-1:0] lat);
      logic [NUM_INTS-1:0] pend;
      prio_t               best;   // Urgency, larger wins
      prio_t               lvl;
      pic_claim_t          c;
      pend = pend_vec(src, lat);
      best = '0;
      c    = '0;
      // Scan upward, strictly greater only so ties stay with the lower id
      for (int i = 1; i < NUM_INTS; i++) begin
         lvl = rev_m ? ~prio_m[i] : prio_m[i];
         if (pend[i] && en_m[i] && (lvl > best)) begin
            best      = lvl;
            c.claimid = int_id_t'(i);
         end
      end
      c.pl = rev_m ? ~best : best;
      if (rev_m) begin
         c.mexintpend = (c.pl < core.meipt) && (c.pl < core.meicurpl);
      end else begin
         c.mexintpend = (c.pl > core.meipt) && (c.pl > core.meicurpl);
      end
      c.mhwakeup = (c.pl == (rev_m ? 4'd0 : MAX_PRIO));
      return c;
   endfunction

   task automatic compare(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         err_cnt++;
         $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end else begin
         pass_cnt++;
      end
   endtask

   task automatic bus_write(input word_t addr, input word_t data);
      @(negedge clk);
      bus.wren    = 1'b1;
      bus.wraddr  = addr;
      bus.wr_data = data;
      @(negedge clk);
      bus.wren = 1'b0;
   endtask

   // Data shows in the cycle after the request is captured
   task automatic read_reg(input word_t ofs, input int i, output word_t d);
      @(negedge clk);
      bus.rden   = 1'b1;
      bus.rdaddr = PIC_BASE_ADDR + ofs + word_t'(4 * i);
      @(negedge clk);
      d        = rd_data;
      bus.rden = 1'b0;
   endtask

   task automatic write_reg(input word_t ofs, input int i, input word_t v);
      bus_write(PIC_BASE_ADDR + ofs + word_t'(4 * i), v);
      if (ofs == CONFIG_OFS) begin
         rev_m = v[0];
      end else if (i != 0) begin
         case (ofs)
            PRIO_OFS:   prio_m[i] = v[PRIO_W-1:0];
            ENABLE_OFS: en_m[i] = v[0];
            GW_CFG_OFS: {edge_m[i], pol_m[i]} = v[1:0];
            GW_CLR_OFS: latch_m[i] = 1'b0;   // Sets again below if still active
            default: ;
         endcase
      end
      update_latches();
   endtask

   task automatic drive_src(input word_t v);
      @(negedge clk);
      src_req = v;
      update_latches();
   endtask

   // Settle past the 3-edge latency, then hand off to the checker
   task automatic check_claim();
      repeat (6) @(negedge clk);
      exp_claim = ref_claim(src_req, latch_m);
      -> do_check;
      @(check_done);
   endtask

   task automatic clear_config();
      for (int i = 1; i < NUM_INTS; i++) begin
         write_reg(ENABLE_OFS, i, 0);
         write_reg(GW_CFG_OFS, i, 0);
      end
      write_reg(CONFIG_OFS, 0, 0);
   endtask

   task automatic random_config(input int n);
      for (int k = 0; k < n; k++) begin
         write_reg(PRIO_OFS, int'(next_rand() % 31) + 1, next_rand());
         write_reg(ENABLE_OFS, int'(next_rand() % 31) + 1, next_rand());
      end
   endtask

   task automatic end_test(input string name, input int e0);
      $display("Test %s finished, %0d errors", name, err_cnt - e0);
   endtask

   initial begin : compare_proc
      forever begin
         @(do_check);
         compare("claimid", word_t'(claim.claimid), word_t'(exp_claim.claimid));
         compare("pl", word_t'(claim.pl), word_t'(exp_claim.pl));
         compare("mexintpend", word_t'(claim.mexintpend), word_t'(exp_claim.mexintpend));
         compare("mhwakeup", word_t'(claim.mhwakeup), word_t'(exp_claim.mhwakeup));
         -> check_done;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////
   task automatic test_regs();
      int    e0;
      word_t d;
      word_t holes [4] = '{PEND_OFS + 4, CONFIG_OFS + 4, GW_CLR_OFS + 12, 32'h6000};
      e0 = err_cnt;
      for (int i = 0; i < NUM_INTS; i++) begin   // Slot 0 writes are dropped
         write_reg(PRIO_OFS, i, next_rand());
         write_reg(ENABLE_OFS, i, next_rand());
         write_reg(GW_CFG_OFS, i, next_rand());
      end
      write_reg(CONFIG_OFS, 0, next_rand());
      write_reg(32'h6000, 3, next_rand());       // Unmapped
      for (int i = 0; i < NUM_INTS; i++) begin
         read_reg(PRIO_OFS, i, d);
         compare($sformatf("priority %0d", i), d, word_t'(prio_m[i]));
         read_reg(ENABLE_OFS, i, d);
         compare($sformatf("enable %0d", i), d, word_t'(en_m[i]));
         read_reg(GW_CFG_OFS, i, d);
         compare($sformatf("gateway config %0d", i), d, word_t'({edge_m[i], pol_m[i]}));
      end
      read_reg(CONFIG_OFS, 0, d);
      compare("global config", d, word_t'(rev_m));
      foreach (holes[k]) begin
         read_reg(holes[k], 0, d);
         compare($sformatf("unmapped offset %0h", holes[k]), d, '0);
      end
      drive_src(next_rand());
      repeat (4) @(negedge clk);
      read_reg(PEND_OFS, 0, d);
      compare("pending word", d, word_t'(pend_vec(src_req, latch_m)));
      end_test("register access", e0);
   endtask

   task automatic test_arb();
      int e0;
      e0 = err_cnt;
      clear_config();
      for (int r = 0; r < 40; r++) begin
         random_config(8);
         drive_src(next_rand());
         check_claim();
      end
      drive_src('0);   // Nothing eligible
      check_claim();
      end_test("level arbitration", e0);
   endtask

   task automatic test_thresh();
      int    e0;
      word_t r;
      e0 = err_cnt;
      for (int n = 0; n < 40; n++) begin
         if (n % 4 == 0) begin
            drive_src(next_rand());
         end
         r = next_rand();
         @(negedge clk);
         core = r[7:0];
         check_claim();
      end
      end_test("threshold gating", e0);
   endtask

   task automatic test_edge();
      int e0;
      e0 = err_cnt;
      clear_config();
      @(negedge clk);
      core = '0;
      drive_src(32'h0000_0200);     // Source 9 high, idle once inverted
      write_reg(PRIO_OFS, 9, 7);
      write_reg(ENABLE_OFS, 9, 1);
      write_reg(GW_CFG_OFS, 9, 3);  // Edge, active low
      check_claim();
      drive_src('0);
      check_claim();
      drive_src(32'h0000_0200);
      check_claim();
      compare("edge claim held", word_t'(claim.claimid), 9);
      write_reg(GW_CLR_OFS, 9, 0);
      check_claim();
      compare("edge claim cleared", word_t'(claim.claimid), 0);
      end_test("edge mode and polarity", e0);
   endtask

   task automatic test_rev();
      int e0;
      e0 = err_cnt;
      clear_config();
      write_reg(CONFIG_OFS, 0, 1);
      for (int r = 0; r < 24; r++) begin
         random_config(6);
         drive_src(next_rand());
         check_claim();
      end
      write_reg(PRIO_OFS, 4, 0);
      write_reg(ENABLE_OFS, 4, 1);
      drive_src(32'h0000_0010);
      check_claim();
      compare("wake-up reversed", word_t'(claim.mhwakeup), 1);
      write_reg(CONFIG_OFS, 0, 0);
      write_reg(PRIO_OFS, 4, 15);
      check_claim();
      compare("wake-up normal", word_t'(claim.mhwakeup), 1);
      end_test("reversed order and wake-up", e0);
   endtask

   initial begin : watchdog
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      arst_n   = 1'b0;
      src_req  = '0;
      bus      = '0;
      core     = '0;
      prio_m   = '{default: '0};
      en_m     = '0;
      pol_m    = '0;
      edge_m   = '0;
      latch_m  = '0;
      rev_m    = 1'b0;
      pass_cnt = 0;
      err_cnt  = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      test_regs();
      test_arb();
      test_thresh();
      test_edge();
      test_rev();
      $display("Summary: %0d checks passed, %0d failed", pass_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: build.f
hdl/pic_pkg.sv
hdl/pic_gateway.sv
hdl/pic_regs.sv
hdl/pic_arbiter.sv
hdl/pic_notify.sv
hdl/pic_top.sv
dv/pic_sva.sv
dv/pic_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the PIC testbench with Verilator, result taken from the log
verilator --binary --timing --assert -f build.f --top-module pic_tb -o pic_sim \
   || { echo "Build failed"; exit 1; }
./obj_dir/pic_sim > sim.log 2>&1
cat sim.log
grep -q -e "CHECKS FAILED" -e "%Error" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
